//--- filelist.f
hdl/jacobi_pkg.sv
hdl/ram_port_if.sv
hdl/matrix_ram.sv
hdl/pair_schedule.sv
hdl/angle_request.sv
hdl/matrix_io.sv
hdl/jacobi_ctrl.sv
hdl/jacobi_top.sv
test/jacobi_tb_assert.sv
test/jacobi_tb.sv

//--- hdl/angle_request.sv
`timescale 1ns/1ps
`default_nettype none

module angle_request (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req_start_i,
  output logic                   req_done_o,
  input  jacobi_pkg::idx_t       pair_i_i,
  input  jacobi_pkg::idx_t       pair_j_i,
  ram_port_if.requester          port_a,
  ram_port_if.requester          port_b,
  output jacobi_pkg::angle_req_t ang_o,
  output logic                   ang_valid_o,
  input  logic                   ang_ready_i
);

  typedef enum logic [2:0] {A_IDLE, A_RD0, A_RD1, A_CALC, A_OFFER} ar_state_t;

  ar_state_t              state_q;
  jacobi_pkg::word_t      wjj_q;
  jacobi_pkg::word_t      wij_q;
  jacobi_pkg::angle_req_t ang_q;
  logic                   fire;

  assign fire = (state_q == A_OFFER) && ang_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= A_IDLE;
    end else begin
      case (state_q)
        A_IDLE: begin
          if (req_start_i) begin
            state_q <= A_RD0;
          end
        end
        A_RD0:   state_q <= A_RD1;
        A_RD1:   state_q <= A_CALC;
        A_CALC:  state_q <= A_OFFER;
        A_OFFER: begin
          if (ang_ready_i) begin
            state_q <= A_IDLE;
          end
        end
        default: state_q <= A_IDLE;
      endcase
    end
  end

  // Wjj and Wij arrive while Wii is being read
  always_ff @(posedge clk) begin
    if (state_q == A_RD1) begin
      wjj_q <= port_a.rdata;
      wij_q <= port_b.rdata;
    end
    if (state_q == A_CALC) begin
      ang_q.i <= pair_i_i;
      ang_q.j <= pair_j_i;
      ang_q.x <= wjj_q - port_a.rdata;
      ang_q.y <= wij_q <<< 1;
    end
  end

  // Diagonal reads on A, off-diagonal read on B
  always_comb begin
    port_a.en    = (state_q == A_RD0) || (state_q == A_RD1);
    port_a.we    = 1'b0;
    port_a.wdata = '0;
    if (state_q == A_RD0) begin
      port_a.addr = jacobi_pkg::elem_addr(1'b0, pair_j_i, pair_j_i);
    end else begin
      port_a.addr = jacobi_pkg::elem_addr(1'b0, pair_i_i, pair_i_i);
    end

    port_b.en    = (state_q == A_RD0);
    port_b.we    = 1'b0;
    port_b.wdata = '0;
    port_b.addr  = jacobi_pkg::elem_addr(1'b0, pair_i_i, pair_j_i);
  end

  assign ang_o       = ang_q;
  assign ang_valid_o = (state_q == A_OFFER);
  assign req_done_o  = fire;

endmodule

`default_nettype wire

//--- hdl/jacobi_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module jacobi_ctrl (
  input  logic          clk,
  input  logic          rst,
  ram_port_if.memory    io_port,
  ram_port_if.memory    ang_port,
  ram_port_if.requester ram_a,
  output logic          init_start_o,
  input  logic          load_done_i,
  output logic          req_start_o,
  input  logic          req_done_i,
  output logic          next_pair_o,
  output logic          next_round_o,
  output logic          send_start_o,
  input  logic          send_done_i
);

  typedef logic [$clog2(jacobi_pkg::N_PAIRS)-1:0]  pair_cnt_t;
  typedef logic [$clog2(jacobi_pkg::N_ROUNDS)-1:0] round_cnt_t;

  jacobi_pkg::phase_t phase_q;
  pair_cnt_t          pair_cnt_q;
  round_cnt_t         round_cnt_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      phase_q      <= jacobi_pkg::INIT;
      pair_cnt_q   <= '0;
      round_cnt_q  <= '0;
      init_start_o <= 1'b0;
      req_start_o  <= 1'b0;
      next_pair_o  <= 1'b0;
      next_round_o <= 1'b0;
      send_start_o <= 1'b0;
    end else begin
      init_start_o <= 1'b0;
      req_start_o  <= 1'b0;
      next_pair_o  <= 1'b0;
      next_round_o <= 1'b0;
      send_start_o <= 1'b0;
      case (phase_q)
        jacobi_pkg::INIT: begin
          init_start_o <= 1'b1;
          phase_q      <= jacobi_pkg::LOAD;
        end
        jacobi_pkg::LOAD: begin
          if (load_done_i) begin
            phase_q     <= jacobi_pkg::ANGLES;
            req_start_o <= 1'b1;
          end
        end
        jacobi_pkg::ANGLES: begin
          if (req_done_i) begin
            next_pair_o <= 1'b1;
          end
          // Start the next request once the new pair is visible
          if (next_pair_o) begin
            if (pair_cnt_q == pair_cnt_t'(jacobi_pkg::N_PAIRS - 1)) begin
              pair_cnt_q   <= '0;
              next_round_o <= 1'b1;
            end else begin
              pair_cnt_q  <= pair_cnt_q + 1'b1;
              req_start_o <= 1'b1;
            end
          end
          if (next_round_o) begin
            if (round_cnt_q == round_cnt_t'(jacobi_pkg::N_ROUNDS - 1)) begin
              round_cnt_q  <= '0;
              phase_q      <= jacobi_pkg::SEND;
              send_start_o <= 1'b1;
            end else begin
              round_cnt_q <= round_cnt_q + 1'b1;
              req_start_o <= 1'b1;
            end
          end
        end
        jacobi_pkg::SEND: begin
          if (send_done_i) begin
            phase_q <= jacobi_pkg::INIT;
          end
        end
        default: phase_q <= jacobi_pkg::INIT;
      endcase
    end
  end

  // Port A belongs to the angle reader only in ANGLES
  always_comb begin
    if (phase_q == jacobi_pkg::ANGLES) begin
      ram_a.en    = ang_port.en;
      ram_a.we    = ang_port.we;
      ram_a.addr  = ang_port.addr;
      ram_a.wdata = ang_port.wdata;
    end else begin
      ram_a.en    = io_port.en;
      ram_a.we    = io_port.we;
      ram_a.addr  = io_port.addr;
      ram_a.wdata = io_port.wdata;
    end
  end

  assign io_port.rdata  = ram_a.rdata;
  assign ang_port.rdata = ram_a.rdata;

endmodule

`default_nettype wire

//--- hdl/jacobi_pkg.sv
`default_nettype none

package jacobi_pkg;

  localparam int N        = 8;
  localparam int LOG2_N   = $clog2(N);
  localparam int N_PAIRS  = N / 2;
  localparam int N_ROUNDS = N - 1;
  localparam int WORD_W   = 16;
  localparam int N_INPUT  = N * N;
  localparam int MEM_SIZE = 2 * N_INPUT;
  localparam int ADDR_W   = $clog2(MEM_SIZE);

  typedef logic signed [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0]        addr_t;
  typedef logic [LOG2_N-1:0]        idx_t;

  // V is stored directly above W
  localparam addr_t V_OFFSET = addr_t'(N_INPUT);
  // Q2.14 one
  localparam word_t V_ONE    = 16'sh4000;

  typedef enum logic [1:0] {INIT, LOAD, ANGLES, SEND} phase_t;

  typedef struct packed {
    idx_t  i;
    idx_t  j;
    word_t x;
    word_t y;
  } angle_req_t;

  // Row-major element address in W or V
  function automatic addr_t elem_addr(input logic v_sel, input idx_t row, input idx_t col);
    addr_t base;
    base = v_sel ? V_OFFSET : '0;
    return base + addr_t'({row, col});
  endfunction

endpackage

`default_nettype wire

//--- hdl/jacobi_top.sv
`timescale 1ns/1ps
`default_nettype none

module jacobi_top (
  input  logic              clk,
  input  logic              rst,
  input  jacobi_pkg::word_t in_data_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  output jacobi_pkg::word_t out_data_o,
  output logic              out_valid_o,
  output logic              out_last_o,
  input  logic              out_ready_i,
  output jacobi_pkg::idx_t  ang_i_o,
  output jacobi_pkg::idx_t  ang_j_o,
  output jacobi_pkg::word_t ang_x_o,
  output jacobi_pkg::word_t ang_y_o,
  output logic              ang_valid_o,
  input  logic              ang_ready_i
);

  logic                   init_start;
  logic                   load_done;
  logic                   send_start;
  logic                   send_done;
  logic                   req_start;
  logic                   req_done;
  logic                   next_pair;
  logic                   next_round;
  jacobi_pkg::idx_t       pair_i;
  jacobi_pkg::idx_t       pair_j;
  jacobi_pkg::angle_req_t ang_req;

  ram_port_if port_a ();
  ram_port_if port_b ();
  ram_port_if io_port ();
  ram_port_if ang_port_a ();

  matrix_ram u_matrix_ram (
    .clk    (clk),
    .port_a (port_a),
    .port_b (port_b)
  );

  pair_schedule u_pair_schedule (
    .clk          (clk),
    .rst          (rst),
    .next_pair_i  (next_pair),
    .next_round_i (next_round),
    .pair_i_o     (pair_i),
    .pair_j_o     (pair_j)
  );

  angle_request u_angle_request (
    .clk         (clk),
    .rst         (rst),
    .req_start_i (req_start),
    .req_done_o  (req_done),
    .pair_i_i    (pair_i),
    .pair_j_i    (pair_j),
    .port_a      (ang_port_a),
    .port_b      (port_b),
    .ang_o       (ang_req),
    .ang_valid_o (ang_valid_o),
    .ang_ready_i (ang_ready_i)
  );

  matrix_io u_matrix_io (
    .clk          (clk),
    .rst          (rst),
    .init_start_i (init_start),
    .load_done_o  (load_done),
    .send_start_i (send_start),
    .send_done_o  (send_done),
    .ram          (io_port),
    .in_data_i    (in_data_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .out_data_o   (out_data_o),
    .out_valid_o  (out_valid_o),
    .out_last_o   (out_last_o),
    .out_ready_i  (out_ready_i)
  );

  jacobi_ctrl u_jacobi_ctrl (
    .clk          (clk),
    .rst          (rst),
    .io_port      (io_port),
    .ang_port     (ang_port_a),
    .ram_a        (port_a),
    .init_start_o (init_start),
    .load_done_i  (load_done),
    .req_start_o  (req_start),
    .req_done_i   (req_done),
    .next_pair_o  (next_pair),
    .next_round_o (next_round),
    .send_start_o (send_start),
    .send_done_i  (send_done)
  );

  assign ang_i_o = ang_req.i;
  assign ang_j_o = ang_req.j;
  assign ang_x_o = ang_req.x;
  assign ang_y_o = ang_req.y;

endmodule

`default_nettype wire

//--- hdl/matrix_io.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_io (
  input  logic              clk,
  input  logic              rst,
  input  logic              init_start_i,
  output logic              load_done_o,
  input  logic              send_start_i,
  output logic              send_done_o,
  ram_port_if.requester     ram,
  input  jacobi_pkg::word_t in_data_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  output jacobi_pkg::word_t out_data_o,
  output logic              out_valid_o,
  output logic              out_last_o,
  input  logic              out_ready_i
);

  typedef enum logic [1:0] {IO_IDLE, IO_INIT, IO_LOAD, IO_SEND} io_state_t;

  localparam jacobi_pkg::idx_t   IDX_LAST  = jacobi_pkg::idx_t'(jacobi_pkg::N - 1);
  localparam jacobi_pkg::addr_t  ADDR_LAST = jacobi_pkg::addr_t'(jacobi_pkg::MEM_SIZE - 1);

  io_state_t         state_q;
  jacobi_pkg::idx_t  row_q;
  jacobi_pkg::idx_t  col_q;
  jacobi_pkg::addr_t rd_addr_q;
  logic              rd_all_q;
  // RAM output register holds a word not yet moved to the output
  logic              rd_valid_q;
  logic              rd_last_q;
  jacobi_pkg::word_t out_data_q;
  logic              out_valid_q;
  logic              out_last_q;
  logic              mat_end;
  logic              in_fire;
  logic              step;
  logic              load_out;
  logic              issue;

  assign mat_end  = (row_q == IDX_LAST) && (col_q == IDX_LAST);
  assign in_fire  = (state_q == IO_LOAD) && in_valid_i;
  assign step     = (state_q == IO_INIT) || in_fire;
  assign load_out = rd_valid_q && (!out_valid_q || out_ready_i);
  assign issue    = (state_q == IO_SEND) && !rd_all_q && (!rd_valid_q || load_out);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IO_IDLE;
    end else begin
      case (state_q)
        IO_IDLE: begin
          if (init_start_i) begin
            state_q <= IO_INIT;
          end else if (send_start_i) begin
            state_q <= IO_SEND;
          end
        end
        IO_INIT: if (mat_end) state_q <= IO_LOAD;
        IO_LOAD: if (in_fire && mat_end) state_q <= IO_IDLE;
        IO_SEND: if (send_done_o) state_q <= IO_IDLE;
        default: state_q <= IO_IDLE;
      endcase
    end
  end

  // Counters wrap to zero after the last element so the load starts at row 0
  always_ff @(posedge clk) begin
    if (rst) begin
      row_q <= '0;
      col_q <= '0;
    end else if (step) begin
      col_q <= col_q + 1'b1;
      if (col_q == IDX_LAST) begin
        row_q <= row_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr_q   <= '0;
      rd_all_q    <= 1'b0;
      rd_valid_q  <= 1'b0;
      out_valid_q <= 1'b0;
      out_last_q  <= 1'b0;
    end else begin
      if (send_start_i) begin
        rd_addr_q <= '0;
        rd_all_q  <= 1'b0;
      end else if (issue) begin
        rd_addr_q <= rd_addr_q + 1'b1;
        rd_all_q  <= (rd_addr_q == ADDR_LAST);
      end

      if (issue) begin
        rd_valid_q <= 1'b1;
      end else if (load_out) begin
        rd_valid_q <= 1'b0;
      end

      if (load_out) begin
        out_valid_q <= 1'b1;
        out_last_q  <= rd_last_q;
      end else if (out_ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      rd_last_q <= (rd_addr_q == ADDR_LAST);
    end
    if (load_out) begin
      out_data_q <= ram.rdata;
    end
  end

  always_comb begin
    ram.en    = 1'b0;
    ram.we    = 1'b0;
    ram.addr  = rd_addr_q;
    ram.wdata = in_data_i;
    case (state_q)
      IO_INIT: begin
        ram.en    = 1'b1;
        ram.we    = 1'b1;
        ram.addr  = jacobi_pkg::elem_addr(1'b1, row_q, col_q);
        ram.wdata = (row_q == col_q) ? jacobi_pkg::V_ONE : '0;
      end
      IO_LOAD: begin
        ram.en   = in_valid_i;
        ram.we   = 1'b1;
        ram.addr = jacobi_pkg::elem_addr(1'b0, row_q, col_q);
      end
      IO_SEND: ram.en = issue;
      default: ram.en = 1'b0;
    endcase
  end

  assign in_ready_o  = (state_q == IO_LOAD);
  assign load_done_o = in_fire && mat_end;
  assign out_data_o  = out_data_q;
  assign out_valid_o = out_valid_q;
  assign out_last_o  = out_last_q;
  assign send_done_o = (state_q == IO_SEND) && out_valid_q && out_ready_i && out_last_q;

endmodule

`default_nettype wire

//--- hdl/matrix_ram.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_ram (
  input logic        clk,
  ram_port_if.memory port_a,
  ram_port_if.memory port_b
);

  jacobi_pkg::word_t mem [jacobi_pkg::MEM_SIZE];

  // Port B is written last so it wins on an address collision
  always_ff @(posedge clk) begin
    if (port_a.en && port_a.we) begin
      mem[port_a.addr] <= port_a.wdata;
    end
    if (port_b.en && port_b.we) begin
      mem[port_b.addr] <= port_b.wdata;
    end
  end

  // Read data only changes on an enabled access
  always_ff @(posedge clk) begin
    if (port_a.en) begin
      port_a.rdata <= mem[port_a.addr];
    end
  end

  always_ff @(posedge clk) begin
    if (port_b.en) begin
      port_b.rdata <= mem[port_b.addr];
    end
  end

endmodule

`default_nettype wire

//--- hdl/pair_schedule.sv
`timescale 1ns/1ps
`default_nettype none

module pair_schedule (
  input  logic             clk,
  input  logic             rst,
  input  logic             next_pair_i,
  input  logic             next_round_i,
  output jacobi_pkg::idx_t pair_i_o,
  output jacobi_pkg::idx_t pair_j_o
);

  localparam int LAST = jacobi_pkg::N_PAIRS - 1;

  // Top row p and bottom row q of the tournament table
  jacobi_pkg::idx_t p_q [jacobi_pkg::N_PAIRS];
  jacobi_pkg::idx_t q_q [jacobi_pkg::N_PAIRS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < jacobi_pkg::N_PAIRS; k++) begin
        p_q[k] <= jacobi_pkg::idx_t'(k);
        q_q[k] <= jacobi_pkg::idx_t'(jacobi_pkg::N - 1 - k);
      end
    end else if (next_round_i) begin
      // Circle method with p0 held in place
      for (int k = 1; k < LAST; k++) begin
        p_q[k] <= p_q[k+1];
      end
      p_q[LAST] <= q_q[LAST];
      for (int k = 1; k <= LAST; k++) begin
        q_q[k] <= q_q[k-1];
      end
      q_q[0] <= p_q[1];
    end else if (next_pair_i) begin
      // Rotate slots so slot 1 moves into slot 0
      for (int k = 0; k < jacobi_pkg::N_PAIRS; k++) begin
        p_q[k] <= p_q[(k + 1) % jacobi_pkg::N_PAIRS];
        q_q[k] <= q_q[(k + 1) % jacobi_pkg::N_PAIRS];
      end
    end
  end

  always_comb begin
    if (p_q[0] < q_q[0]) begin
      pair_i_o = p_q[0];
      pair_j_o = q_q[0];
    end else begin
      pair_i_o = q_q[0];
      pair_j_o = p_q[0];
    end
  end

endmodule

`default_nettype wire

//--- hdl/ram_port_if.sv
`timescale 1ns/1ps
`default_nettype none

// One RAM port with read data one cycle after an enabled read
interface ram_port_if;

  logic              en;
  logic              we;
  jacobi_pkg::addr_t addr;
  jacobi_pkg::word_t wdata;
  jacobi_pkg::word_t rdata;

  modport requester (
    output en,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  modport memory (
    input  en,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

//--- test/jacobi_tb.sv
`timescale 1ns/1ps
`default_nettype none

module jacobi_tb;

  localparam int          N          = 8;
  localparam int          N_WORDS    = 64;
  localparam int          N_REQS     = 28;
  localparam logic [15:0] V_DIAG     = 16'h4000;
  localparam int          MAX_CYCLES = 4 * (64 + 64 + 28 * 8 + 128) * 2;

  logic              clk;
  logic              rst;
  jacobi_pkg::word_t in_data_i;
  logic              in_valid_i;
  logic              in_ready_o;
  jacobi_pkg::word_t out_data_o;
  logic              out_valid_o;
  logic              out_last_o;
  logic              out_ready_i;
  jacobi_pkg::idx_t  ang_i_o;
  jacobi_pkg::idx_t  ang_j_o;
  jacobi_pkg::word_t ang_x_o;
  jacobi_pkg::word_t ang_y_o;
  logic              ang_valid_o;
  logic              ang_ready_i;

  // Reference copy of the loaded W and the tournament slots
  logic [15:0] w_model [N_WORDS];
  int          p_slot [4];
  int          q_slot [4];
  int          cycle_count = 0;
  int          err_count;
  int          test_count;
  int          bad_tests;
  int          assert_fails;

  jacobi_top u_jacobi_top (
    .clk         (clk),
    .rst         (rst),
    .in_data_i   (in_data_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_data_o  (out_data_o),
    .out_valid_o (out_valid_o),
    .out_last_o  (out_last_o),
    .out_ready_i (out_ready_i),
    .ang_i_o     (ang_i_o),
    .ang_j_o     (ang_j_o),
    .ang_x_o     (ang_x_o),
    .ang_y_o     (ang_y_o),
    .ang_valid_o (ang_valid_o),
    .ang_ready_i (ang_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: run did not complete within %0d cycles", MAX_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [15:0] got,
                             input logic [15:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic require(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("Error at %0t: %s", $time, what);
      err_count++;
    end
  endtask

  task automatic end_test(input string name, input int start_errs);
    test_count++;
    if (err_count == start_errs) begin
      $display("Test %s: ok", name);
    end else begin
      bad_tests++;
      $display("Test %s: %0d errors", name, err_count - start_errs);
    end
  endtask

  // Slot 1 moves into slot 0
  task automatic rotate_slots();
    int p0;
    int q0;
    p0 = p_slot[0];
    q0 = q_slot[0];
    for (int k = 0; k < 3; k++) begin
      p_slot[k] = p_slot[k+1];
      q_slot[k] = q_slot[k+1];
    end
    p_slot[3] = p0;
    q_slot[3] = q0;
  endtask

  // Circle method step with index p0 fixed
  task automatic advance_round();
    int old_p [4];
    int old_q [4];
    old_p = p_slot;
    old_q = q_slot;
    p_slot[1] = old_p[2];
    p_slot[2] = old_p[3];
    p_slot[3] = old_q[3];
    q_slot[3] = old_q[2];
    q_slot[2] = old_q[1];
    q_slot[1] = old_q[0];
    q_slot[0] = old_p[1];
  endtask

  task automatic wait_init();
    int start_errs;
    start_errs = err_count;
    @(negedge clk);
    require(!in_ready_o, "in_ready_o high directly after reset");
    while (!in_ready_o) begin
      require(!out_valid_o && !ang_valid_o, "output valid before the first load");
      @(negedge clk);
    end
    end_test("reset state", start_errs);
  endtask

  task automatic load_matrix(input int pass);
    int          start_errs;
    int          sent;
    logic [15:0] val;
    start_errs = err_count;
    // Symmetric random matrix
    for (int r = 0; r < N; r++) begin
      for (int c = r; c < N; c++) begin
        val = 16'($urandom);
        w_model[r*N+c] = val;
        w_model[c*N+r] = val;
      end
    end
    sent = 0;
    while (sent < N_WORDS) begin
      @(negedge clk);
      require(!out_valid_o && !ang_valid_o, "output valid during matrix load");
      out_ready_i = ($urandom % 2) == 1;
      ang_ready_i = ($urandom % 2) == 1;
      in_valid_i  = ($urandom % 4) != 0;
      in_data_i   = in_valid_i ? w_model[sent] : 16'($urandom);
      if (in_valid_i && in_ready_o) begin
        sent++;
      end
    end
    @(negedge clk);
    in_valid_i = 1'b0;
    in_data_i  = '0;
    end_test($sformatf("load %0d", pass), start_errs);
  endtask

  task automatic collect_angles(input int pass);
    int          start_errs;
    int          got;
    int          distinct;
    int          i_exp;
    int          j_exp;
    logic [15:0] x_exp;
    logic [15:0] y_exp;
    bit          seen [N][N];
    start_errs = err_count;
    got = 0;
    distinct = 0;
    for (int a = 0; a < N; a++) begin
      for (int b = 0; b < N; b++) begin
        seen[a][b] = 1'b0;
      end
    end
    while (got < N_REQS) begin
      @(negedge clk);
      require(!out_valid_o, "out_valid_o high during angle requests");
      out_ready_i = ($urandom % 2) == 1;
      ang_ready_i = ($urandom % 3) != 0;
      if (ang_valid_o && ang_ready_i) begin
        i_exp = (p_slot[0] < q_slot[0]) ? p_slot[0] : q_slot[0];
        j_exp = (p_slot[0] < q_slot[0]) ? q_slot[0] : p_slot[0];
        check_value($sformatf("request %0d i", got), 16'(ang_i_o), 16'(i_exp));
        check_value($sformatf("request %0d j", got), 16'(ang_j_o), 16'(j_exp));
        require(ang_i_o < ang_j_o, "angle request with i not below j");
        if (!seen[ang_i_o][ang_j_o]) begin
          distinct++;
        end
        seen[ang_i_o][ang_j_o] = 1'b1;
        x_exp = w_model[j_exp*N+j_exp] - w_model[i_exp*N+i_exp];
        y_exp = {w_model[i_exp*N+j_exp][14:0], 1'b0};
        check_value($sformatf("request %0d x", got), ang_x_o, x_exp);
        check_value($sformatf("request %0d y", got), ang_y_o, y_exp);
        got++;
        rotate_slots();
        if (got % 4 == 0) begin
          advance_round();
        end
      end
    end
    require(distinct == N_REQS, "the sweep did not cover all 28 pairs");
    end_test($sformatf("angles %0d", pass), start_errs);
  endtask

  task automatic collect_readout(input int pass);
    int          start_errs;
    int          got;
    int          v;
    logic [15:0] exp;
    start_errs = err_count;
    got = 0;
    while (got < 2 * N_WORDS) begin
      @(negedge clk);
      require(!ang_valid_o, "ang_valid_o high during readout");
      ang_ready_i = ($urandom % 2) == 1;
      out_ready_i = ($urandom % 3) != 0;
      if (out_valid_o && out_ready_i) begin
        v = got - N_WORDS;
        if (got < N_WORDS) begin
          exp = w_model[got];
        end else begin
          exp = (v / N == v % N) ? V_DIAG : 16'h0000;
        end
        check_value($sformatf("readout word %0d", got), out_data_o, exp);
        check_value($sformatf("last on word %0d", got), {15'b0, out_last_o},
                    {15'b0, got == 2 * N_WORDS - 1});
        got++;
      end
    end
    @(negedge clk);
    out_ready_i = 1'b0;
    require(!out_valid_o, "extra output word after the last one");
    end_test($sformatf("readout %0d", pass), start_errs);
  endtask

  initial begin
    void'($urandom(32'h05bf_95e8));
    rst         = 1'b1;
    in_data_i   = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    ang_ready_i = 1'b0;
    err_count   = 0;
    test_count  = 0;
    bad_tests   = 0;
    for (int k = 0; k < 4; k++) begin
      p_slot[k] = k;
      q_slot[k] = N - 1 - k;
    end
    repeat (2) @(negedge clk);
    rst = 1'b0;

    wait_init();
    for (int pass = 1; pass <= 2; pass++) begin
      load_matrix(pass);
      collect_angles(pass);
      collect_readout(pass);
    end

    assert_fails = u_jacobi_top.u_tb_assert.fail_count;
    err_count += assert_fails;
    $display("Summary: %0d tests, %0d with errors, %0d errors, %0d assertion failures",
             test_count, bad_tests, err_count, assert_fails);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/jacobi_tb_assert.sv
`timescale 1ns/1ps
`default_nettype none

module jacobi_tb_assert (
  input logic              clk,
  input logic              rst,
  input logic              in_ready_o,
  input jacobi_pkg::word_t out_data_o,
  input logic              out_valid_o,
  input logic              out_last_o,
  input logic              out_ready_i,
  input jacobi_pkg::idx_t  ang_i_o,
  input jacobi_pkg::idx_t  ang_j_o,
  input jacobi_pkg::word_t ang_x_o,
  input jacobi_pkg::word_t ang_y_o,
  input logic              ang_valid_o,
  input logic              ang_ready_i
);

  int fail_count = 0;

  // A stalled output word stays put until it is taken
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=>
      out_valid_o && $stable(out_data_o) && $stable(out_last_o))
  else begin
    $error("Readout word changed or vanished while stalled");
    fail_count++;
  end

  a_ang_hold: assert property (@(posedge clk) disable iff (rst)
    ang_valid_o && !ang_ready_i |=>
      ang_valid_o && $stable(ang_i_o) && $stable(ang_j_o)
      && $stable(ang_x_o) && $stable(ang_y_o))
  else begin
    $error("Angle request changed or vanished while stalled");
    fail_count++;
  end

  // Load never overlaps with either output phase
  a_phase_excl: assert property (@(posedge clk) disable iff (rst)
    !(in_ready_o && (ang_valid_o || out_valid_o)))
  else begin
    $error("Input ready while an output is valid");
    fail_count++;
  end

endmodule

bind jacobi_top jacobi_tb_assert u_tb_assert (
  .clk         (clk),
  .rst         (rst),
  .in_ready_o  (in_ready_o),
  .out_data_o  (out_data_o),
  .out_valid_o (out_valid_o),
  .out_last_o  (out_last_o),
  .out_ready_i (out_ready_i),
  .ang_i_o     (ang_i_o),
  .ang_j_o     (ang_j_o),
  .ang_x_o     (ang_x_o),
  .ang_y_o     (ang_y_o),
  .ang_valid_o (ang_valid_o),
  .ang_ready_i (ang_ready_i)
);

`default_nettype wire
